// File: common/pipe_pkg.sv
package pipe_pkg;

    import rv_isa_pkg::*;

    // Control word produced in decode and carried down the pipe.
    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    reg_write;
        logic    mem_to_reg;
    } ctrl_t;

    ////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////

    typedef struct packed {
        word_t     pc;
        word_t     imm;
        word_t     rs1_data;
        word_t     rs2_data;
        ctrl_t     ctrl;
        funct3_t   funct3;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        word_t     alu_result;
        word_t     branch_target;
        word_t     rs2_data;
        ctrl_t     ctrl;
        funct3_t   funct3;
        reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        word_t     alu_result;
        logic      mem_to_reg;
        logic      reg_write;
        reg_addr_t rd;
    } mem_wb_t;

endpackage

// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

    ////////////////////////////////////////
    // Widths and field types
    ////////////////////////////////////////

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // x0 always reads as zero.
    localparam reg_addr_t reg_zero = 5'd0;

    // addi x0, x0, 0
    localparam instr_t nop_instr = 32'h0000_0013;

    ////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////

    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_fence  = 7'b0001111,
        op_imm    = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111,
        op_system = 7'b1110011
    } opcode_t;

    // ALU encodings of funct3.
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    // Branch encodings of funct3.
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    // Selects sub and sra.
    localparam funct7_t funct7_alt = 7'b0100000;

    // alu_add is zero so that an all-zero control word is a no-op.
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

endpackage

// File: decode/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder import rv_isa_pkg::*, pipe_pkg::*; (
    input  instr_t instr,
    output ctrl_t  ctrl,
    output word_t  imm
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    alu_op_t arith_op;
    alu_op_t branch_op;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // ALU operation for register and immediate arithmetic.
    always_comb begin
        arith_op = alu_add;
        case (funct3)
            f3_add_sub: begin
                // There is no subi, so funct7 only counts for register ops.
                if (opcode == op_reg && funct7 == funct7_alt) begin
                    arith_op = alu_sub;
                end
            end
            f3_sll:  arith_op = alu_sll;
            f3_slt:  arith_op = alu_slt;
            f3_sltu: arith_op = alu_sltu;
            f3_xor:  arith_op = alu_xor;
            f3_srl_sra: begin
                arith_op = (funct7 == funct7_alt) ? alu_sra : alu_srl;
            end
            f3_or:   arith_op = alu_or;
            f3_and:  arith_op = alu_and;
        endcase
    end

    // Branch compare. Equality tests look at the zero flag of a subtract.
    always_comb begin
        case (funct3)
            f3_blt, f3_bge:   branch_op = alu_slt;
            f3_bltu, f3_bgeu: branch_op = alu_sltu;
            default:          branch_op = alu_sub;
        endcase
    end

    ////////////////////////////////////////
    // Control word
    ////////////////////////////////////////

    always_comb begin
        ctrl = '0;
        case (opcode)
            op_reg: begin
                ctrl.alu_op    = arith_op;
                ctrl.reg_write = 1'b1;
            end
            op_imm: begin
                ctrl.alu_op    = arith_op;
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_load: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            op_store: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_branch: begin
                ctrl.alu_op = branch_op;
                ctrl.branch = 1'b1;
            end
            default: begin
                // Jumps, lui, auipc and the rest fall through as bubbles.
                ctrl = '0;
            end
        endcase

        // The canonical nop carries the same all-zero control as a reset bubble.
        if (instr == nop_instr) begin
            ctrl = '0;
        end
    end

    ////////////////////////////////////////
    // Immediate
    ////////////////////////////////////////

    always_comb begin
        case (opcode)
            op_store: begin
                imm = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
            end
            op_branch: begin
                imm = {{(xlen-13){instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            default: begin
                // I-type. For shifts the low 5 bits are the shift amount.
                imm = {{(xlen-12){instr[31]}}, instr[31:20]};
            end
        endcase
    end

endmodule

// File: decode/reg_file.sv
`timescale 1ns/100ps

module reg_file import rv_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      we,
    input  reg_addr_t rd,
    input  word_t     wd
);

    word_t regs [2**$bits(reg_addr_t)];
    logic  wr_en;

    // x0 is never written, so it keeps its reset value.
    assign wr_en = we && (rd != reg_zero);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**$bits(reg_addr_t); i++) begin
                regs[i] <= '0;
            end
            rs1_data <= '0;
            rs2_data <= '0;
        end else begin
            if (wr_en) begin
                regs[rd] <= wd;
            end

            // Same-cycle write is passed straight to the read flops.
            rs1_data <= (wr_en && rd == rs1) ? wd : regs[rs1];
            rs2_data <= (wr_en && rd == rs2) ? wd : regs[rs2];
        end
    end

endmodule

// File: dv/riscv_pipeline_sva.sv
`timescale 1ns/100ps

module riscv_pipeline_sva import rv_isa_pkg::*; (
    input logic  clk,
    input logic  rst,
    input word_t pc,
    input logic  mem_read,
    input logic  mem_write
);

    ////////////////////////////////////////
    // Memory strobes
    ////////////////////////////////////////

    // A stage holds a load or a store, never both.
    no_read_write_overlap: assert property (
        @(posedge clk) disable iff (rst) !(mem_read && mem_write)
    ) else $error("mem_read and mem_write are high together");

    // The pipe is still full of bubbles right after reset.
    idle_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !mem_write
    ) else $error("mem_write high in the first cycle after reset");

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////

    pc_word_aligned: assert property (
        @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
    ) else $error("pc is not word aligned");

endmodule

// File: dv/riscv_pipeline_tb.sv
`timescale 1ns/100ps

module riscv_pipeline_tb import rv_isa_pkg::*;;

    localparam word_t start_pc   = 32'h0040_0000;
    localparam word_t lfsr_seed  = 32'h4356_6aae;
    localparam int    imem_words = 512;
    localparam int    dmem_words = 256;

    logic   clk;
    logic   rst;
    instr_t instruction;
    word_t  d_read_data;
    word_t  pc;
    word_t  alu_result;
    word_t  d_address;
    word_t  d_write_data;
    word_t  write_back_data;
    logic   mem_read;
    logic   mem_write;

    instr_t imem [imem_words];
    word_t  dmem [dmem_words];
    word_t  ref_mem [dmem_words];
    word_t  store_addr_q [$];
    word_t  store_data_q [$];
    word_t  br_pc_q [$];
    word_t  br_next_q [$];
    word_t  alu_pc_q [$];
    word_t  alu_exp_q [$];
    word_t  wb_pc_q [$];
    word_t  wb_exp_q [$];
    // Expected PCs of the last four samples.
    word_t  pc_hist [4];
    word_t  exp_pc;
    int     prog_len;
    int     samples;
    int     errors;
    int     checks;
    logic   running;

    riscv_pipeline #(
        .initial_pc(start_pc)
    ) u_riscv_pipeline (
        .clk            (clk),
        .rst            (rst),
        .instruction    (instruction),
        .d_read_data    (d_read_data),
        .pc             (pc),
        .alu_result     (alu_result),
        .d_address      (d_address),
        .d_write_data   (d_write_data),
        .write_back_data(write_back_data),
        .mem_read       (mem_read),
        .mem_write      (mem_write)
    );

    bind riscv_pipeline riscv_pipeline_sva u_riscv_pipeline_sva (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .mem_read (mem_read),
        .mem_write(mem_write)
    );

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////

    function automatic instr_t reg_op(logic [6:0] f7, int rd, int rs1, int rs2, logic [2:0] f3);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic instr_t imm_op(opcode_t opc, int rd, logic [2:0] f3, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic instr_t store_op(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic instr_t branch_op(logic [2:0] f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // Three nops after every instruction keep dependent ones far enough apart.
    task automatic emit_slot(instr_t w);
        imem[prog_len] = w;
        prog_len += 4;
    endtask

    // The store in the shadow slot is skipped only when the branch is taken.
    task automatic branch_case(logic [2:0] f3, int rs1, int rs2, int k);
        emit_slot(branch_op(f3, rs1, rs2, 32));
        emit_slot(store_op(4, 25, 24 + 4 * k));
    endtask

    task automatic build_program();
        int k;
        prog_len = 0;
        for (k = 0; k < imem_words; k++) begin
            imem[k] = nop_instr;
        end
        emit_slot(imm_op(op_imm, 1, 3'b000, 0, 256));
        emit_slot(imm_op(op_imm, 2, 3'b000, 0, -7));
        emit_slot(imm_op(op_imm, 3, 3'b000, 0, 37));
        emit_slot(imm_op(op_imm, 4, 3'b000, 0, 'h5a5));
        emit_slot(imm_op(op_imm, 25, 3'b000, 0, 600));
        // Register forms, shift amount 37 in rs2.
        emit_slot(reg_op(7'h00, 5, 2, 4, 3'b000));
        emit_slot(reg_op(7'h20, 6, 2, 4, 3'b000));
        emit_slot(reg_op(7'h00, 7, 4, 3, 3'b001));
        emit_slot(reg_op(7'h00, 8, 2, 4, 3'b010));
        emit_slot(reg_op(7'h00, 9, 2, 4, 3'b011));
        emit_slot(reg_op(7'h00, 10, 2, 4, 3'b100));
        emit_slot(reg_op(7'h00, 11, 2, 3, 3'b101));
        emit_slot(reg_op(7'h20, 12, 2, 3, 3'b101));
        emit_slot(reg_op(7'h00, 13, 2, 4, 3'b110));
        emit_slot(reg_op(7'h00, 14, 2, 4, 3'b111));
        // Immediate forms.
        emit_slot(imm_op(op_imm, 15, 3'b000, 2, -100));
        emit_slot(imm_op(op_imm, 16, 3'b010, 4, -1));
        emit_slot(imm_op(op_imm, 17, 3'b011, 2, 5));
        emit_slot(imm_op(op_imm, 18, 3'b100, 4, -1));
        emit_slot(imm_op(op_imm, 19, 3'b110, 2, 'h0f0));
        emit_slot(imm_op(op_imm, 20, 3'b111, 4, 'h7f));
        emit_slot(imm_op(op_imm, 21, 3'b001, 2, 31));
        emit_slot(imm_op(op_imm, 22, 3'b101, 2, 4));
        emit_slot(imm_op(op_imm, 23, 3'b101, 2, 'h404));
        for (k = 5; k <= 23; k++) begin
            emit_slot(store_op(k, 1, (k - 14) * 4));
        end
        // Load, use and store back.
        emit_slot(imm_op(op_load, 24, 3'b010, 25, -20));
        emit_slot(reg_op(7'h00, 26, 24, 2, 3'b000));
        emit_slot(store_op(26, 25, 12));
        emit_slot(store_op(24, 25, 16));
        // Writes to x0 must vanish.
        emit_slot(imm_op(op_imm, 0, 3'b000, 4, 5));
        emit_slot(reg_op(7'h00, 0, 4, 4, 3'b000));
        emit_slot(store_op(0, 25, 20));
        branch_case(3'b000, 4, 4, 0);
        branch_case(3'b000, 2, 4, 1);
        branch_case(3'b001, 2, 4, 2);
        branch_case(3'b001, 4, 4, 3);
        branch_case(3'b100, 2, 4, 4);
        branch_case(3'b100, 4, 2, 5);
        branch_case(3'b101, 4, 4, 6);
        branch_case(3'b101, 2, 4, 7);
        branch_case(3'b110, 4, 2, 8);
        branch_case(3'b110, 2, 4, 9);
        branch_case(3'b111, 2, 4, 10);
        branch_case(3'b111, 4, 2, 11);
        emit_slot(store_op(2, 25, 100));
    endtask

    ////////////////////////////////////////
    // Memories
    ////////////////////////////////////////

    function automatic word_t lfsr_next(word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic fill_data();
        word_t state;
        word_t w;
        int    i;
        int    j;
        state = lfsr_seed;
        for (i = 0; i < dmem_words; i++) begin
            w = '0;
            for (j = 0; j < 32; j++) begin
                state = lfsr_next(state);
                w = {w[30:0], state[0]};
            end
            dmem[i] = w;
            ref_mem[i] = w;
        end
    endtask

    function automatic instr_t fetch_word(word_t addr);
        word_t offs;
        offs = (addr - start_pc) >> 2;
        if (offs < word_t'(imem_words)) begin
            return imem[offs[8:0]];
        end
        return nop_instr;
    endfunction

    always @(posedge clk) begin
        instruction <= rst ? nop_instr : fetch_word(pc);
        if (mem_write) begin
            dmem[d_address[9:2]] <= d_write_data;
        end
        d_read_data <= dmem[d_address[9:2]];
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return (sa < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return !($signed(a) < $signed(b));
            3'b110: return a < b;
            3'b111: return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    // Plain sequential execution of the program.
    function automatic void run_reference();
        word_t    regs [32];
        word_t    rpc;
        word_t    npc;
        word_t    a;
        word_t    b;
        word_t    res;
        word_t    addr;
        word_t    imm_i;
        word_t    imm_s;
        word_t    imm_b;
        instr_t   ins;
        logic [2:0] f3;
        logic     wr;
        int       i;
        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        rpc = start_pc;
        i = 0;
        while (((rpc - start_pc) >> 2) < word_t'(prog_len) && i < 4096) begin
            ins = fetch_word(rpc);
            a = regs[ins[19:15]];
            b = regs[ins[24:20]];
            f3 = ins[14:12];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            npc = rpc + 32'd4;
            wr = 1'b0;
            res = '0;
            case (opcode_t'(ins[6:0]))
                op_reg: begin
                    res = alu_ref(f3, ins[30], a, b);
                    wr = 1'b1;
                    alu_pc_q.push_back(rpc);
                    alu_exp_q.push_back(res);
                end
                op_imm: begin
                    res = alu_ref(f3, ins[30] && f3 == 3'b101, a, imm_i);
                    wr = 1'b1;
                    alu_pc_q.push_back(rpc);
                    alu_exp_q.push_back(res);
                end
                op_load: begin
                    addr = a + imm_i;
                    res = ref_mem[addr[9:2]];
                    wr = 1'b1;
                    alu_pc_q.push_back(rpc);
                    alu_exp_q.push_back(addr);
                end
                op_store: begin
                    addr = a + imm_s;
                    ref_mem[addr[9:2]] = b;
                    store_addr_q.push_back(addr);
                    store_data_q.push_back(b);
                    alu_pc_q.push_back(rpc);
                    alu_exp_q.push_back(addr);
                end
                op_branch: begin
                    br_pc_q.push_back(rpc);
                    if (branch_ref(f3, a, b)) begin
                        npc = rpc + imm_b;
                        br_next_q.push_back(npc);
                    end else begin
                        br_next_q.push_back(rpc + 32'd16);
                    end
                end
                default: begin
                end
            endcase
            // The write-back value shows even when rd is x0.
            if (wr) begin
                wb_pc_q.push_back(rpc);
                wb_exp_q.push_back(res);
            end
            if (wr && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = res;
            end
            rpc = npc;
            i++;
        end
    endfunction

    ////////////////////////////////////////
    // Compare
    ////////////////////////////////////////

    task automatic compare_word(string name, word_t expected, word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic int pending_checks();
        return store_addr_q.size() + br_pc_q.size() + alu_pc_q.size() + wb_pc_q.size();
    endfunction

    always @(negedge clk) begin
        if (running) begin
            if (samples == 0) begin
                exp_pc = start_pc;
                compare_word("reset pc", exp_pc, pc);
                compare_word("reset mem_read", '0, word_t'(mem_read));
                compare_word("reset mem_write", '0, word_t'(mem_write));
            end else if (samples >= 4 && br_pc_q.size() > 0 && pc_hist[3] == br_pc_q[0]) begin
                // Four fetches after the branch the redirect is visible.
                void'(br_pc_q.pop_front());
                exp_pc = br_next_q.pop_front();
                compare_word("branch redirect", exp_pc, pc);
            end else begin
                exp_pc = pc_hist[0] + 32'd4;
                compare_word("sequential pc", exp_pc, pc);
            end
            // Execute is two samples after fetch, write-back four.
            if (samples >= 2 && alu_pc_q.size() > 0 && pc_hist[1] == alu_pc_q[0]) begin
                void'(alu_pc_q.pop_front());
                compare_word("alu result", alu_exp_q.pop_front(), alu_result);
            end
            if (samples >= 4 && wb_pc_q.size() > 0 && pc_hist[3] == wb_pc_q[0]) begin
                void'(wb_pc_q.pop_front());
                compare_word("write-back data", wb_exp_q.pop_front(), write_back_data);
            end
            if (mem_write) begin
                if (store_addr_q.size() == 0) begin
                    errors++;
                    $display("Unexpected store of %h to address %h", d_write_data, d_address);
                end else begin
                    compare_word("store address", store_addr_q.pop_front(), d_address);
                    compare_word("store data", store_data_q.pop_front(), d_write_data);
                end
            end
            pc_hist[3] = pc_hist[2];
            pc_hist[2] = pc_hist[1];
            pc_hist[1] = pc_hist[0];
            pc_hist[0] = exp_pc;
            samples++;
        end
    end

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        int wait_cycles;
        rst = 1'b1;
        instruction = nop_instr;
        d_read_data = '0;
        running = 1'b0;
        samples = 0;
        errors = 0;
        checks = 0;
        build_program();
        fill_data();
        run_reference();

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        running <= 1'b1;

        wait_cycles = 0;
        while (pending_checks() != 0 && wait_cycles < 2000) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (pending_checks() != 0) begin
            errors++;
            $display("Timeout with %0d expected stores, branches and results not seen",
                     pending_checks());
        end

        // A few more cycles to catch stray stores.
        wait_cycles = 0;
        while (wait_cycles < 16) begin
            @(posedge clk);
            wait_cycles++;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module riscv_pipeline_tb \
    -f verilog.f \
    --Mdir obj_dir -o riscv_pipeline_sim

out=$(./obj_dir/riscv_pipeline_sim)
echo "$out"

if grep -qx "RESULT: PASS" <<< "$out"; then
    exit 0
fi
exit 1

// File: src/alu.sv
`timescale 1ns/100ps

module alu import rv_isa_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    zero
);

    logic [4:0] shamt;

    // Only the low five bits count as a shift amount.
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = word_t'($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: src/branch_resolve.sv
`timescale 1ns/100ps

module branch_resolve import rv_isa_pkg::*; (
    input  logic    branch,
    input  funct3_t funct3,
    input  logic    zero,
    input  logic    lt,
    output logic    taken
);

    // zero comes from a subtract, lt from slt or sltu.
    always_comb begin
        taken = 1'b0;
        if (branch) begin
            case (funct3)
                f3_beq:          taken = zero;
                f3_bne:          taken = !zero;
                f3_blt, f3_bltu: taken = lt;
                f3_bge, f3_bgeu: taken = !lt;
                default:         taken = 1'b0;
            endcase
        end
    end

endmodule

// File: src/pc_fetch.sv
`timescale 1ns/100ps

module pc_fetch import rv_isa_pkg::*; #(
    parameter word_t initial_pc = 32'h0040_0000
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  taken,
    input  word_t target,
    output word_t pc
);

    // Sequential fetch unless a resolved branch redirects.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= initial_pc;
        end else if (taken) begin
            pc <= target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

endmodule

// File: src/riscv_pipeline.sv
`timescale 1ns/100ps

module riscv_pipeline import rv_isa_pkg::*, pipe_pkg::*; #(
    parameter word_t initial_pc = 32'h0040_0000
) (
    input  logic   clk,
    input  logic   rst,
    input  instr_t instruction,
    input  word_t  d_read_data,
    output word_t  pc,
    output word_t  alu_result,
    output word_t  d_address,
    output word_t  d_write_data,
    output word_t  write_back_data,
    output logic   mem_read,
    output logic   mem_write
);

    word_t   pc_id;
    ctrl_t   id_ctrl;
    word_t   id_imm;
    word_t   rs1_data;
    word_t   rs2_data;
    id_ex_t  id_ex_q;
    id_ex_t  id_ex;
    word_t   alu_b;
    logic    ex_zero;
    ex_mem_t ex_mem;
    logic    mem_zero;
    logic    mem_taken;
    mem_wb_t mem_wb;

    ////////////////////////////////////////
    // IF
    ////////////////////////////////////////

    pc_fetch #(
        .initial_pc(initial_pc)
    ) u_pc_fetch (
        .clk   (clk),
        .rst   (rst),
        .taken (mem_taken),
        .target(ex_mem.branch_target),
        .pc    (pc)
    );

    ////////////////////////////////////////
    // ID
    ////////////////////////////////////////

    // Instruction memory answers one cycle late, so the PC is delayed to match.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_id <= '0;
        end else begin
            pc_id <= pc;
        end
    end

    instr_decoder u_instr_decoder (
        .instr(instruction),
        .ctrl (id_ctrl),
        .imm  (id_imm)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rs1     (instruction[19:15]),
        .rs2     (instruction[24:20]),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .we      (mem_wb.reg_write),
        .rd      (mem_wb.rd),
        .wd      (write_back_data)
    );

    // Operand data gets here through the register file's own output flops.
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= '{pc: pc_id, imm: id_imm, rs1_data: '0, rs2_data: '0,
                         ctrl: id_ctrl, funct3: instruction[14:12],
                         rd: instruction[11:7]};
        end
    end

    always_comb begin
        id_ex = id_ex_q;
        id_ex.rs1_data = rs1_data;
        id_ex.rs2_data = rs2_data;
    end

    ////////////////////////////////////////
    // EX
    ////////////////////////////////////////

    assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : id_ex.rs2_data;

    alu u_alu (
        .op    (id_ex.ctrl.alu_op),
        .a     (id_ex.rs1_data),
        .b     (alu_b),
        .result(alu_result),
        .zero  (ex_zero)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem   <= '0;
            mem_zero <= 1'b0;
        end else begin
            ex_mem <= '{alu_result: alu_result,
                        branch_target: id_ex.pc + id_ex.imm,
                        rs2_data: id_ex.rs2_data, ctrl: id_ex.ctrl,
                        funct3: id_ex.funct3, rd: id_ex.rd};
            mem_zero <= ex_zero;
        end
    end

    ////////////////////////////////////////
    // MEM
    ////////////////////////////////////////

    // Bit 0 of an slt/sltu result is the less-than flag.
    branch_resolve u_branch_resolve (
        .branch(ex_mem.ctrl.branch),
        .funct3(ex_mem.funct3),
        .zero  (mem_zero),
        .lt    (ex_mem.alu_result[0]),
        .taken (mem_taken)
    );

    assign d_address    = ex_mem.alu_result;
    assign d_write_data = ex_mem.rs2_data;
    assign mem_read     = ex_mem.ctrl.mem_read;
    assign mem_write    = ex_mem.ctrl.mem_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{alu_result: ex_mem.alu_result,
                        mem_to_reg: ex_mem.ctrl.mem_to_reg,
                        reg_write: ex_mem.ctrl.reg_write, rd: ex_mem.rd};
        end
    end

    ////////////////////////////////////////
    // WB
    ////////////////////////////////////////

    // Load data shows up on d_read_data in this cycle.
    assign write_back_data = mem_wb.mem_to_reg ? d_read_data : mem_wb.alu_result;

endmodule

// File: verilog.f
common/rv_isa_pkg.sv
common/pipe_pkg.sv
decode/instr_decoder.sv
decode/reg_file.sv
src/pc_fetch.sv
src/alu.sv
src/branch_resolve.sv
src/riscv_pipeline.sv
dv/riscv_pipeline_sva.sv
dv/riscv_pipeline_tb.sv
